// ==== rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

	// --------------------------------------------------------------------------
	// major opcodes of the RV32I subset
	// --------------------------------------------------------------------------
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcode_e;

	// funct3 of the conditional branches
	typedef enum logic [2:0] {
		F3_BEQ  = 3'b000,
		F3_BNE  = 3'b001,
		F3_BLT  = 3'b100,
		F3_BGE  = 3'b101,
		F3_BLTU = 3'b110,
		F3_BGEU = 3'b111
	} branch_funct3_e;

	// funct3 of OP and OP-IMM
	typedef enum logic [2:0] {
		F3_ADD_SUB = 3'b000,
		F3_SLL     = 3'b001,
		F3_SLT     = 3'b010,
		F3_SLTU    = 3'b011,
		F3_XOR     = 3'b100,
		F3_SR      = 3'b101,
		F3_OR      = 3'b110,
		F3_AND     = 3'b111
	} alu_funct3_e;

	// addi x0, x0, 0
	localparam logic [31:0] NOP_INST = 32'h0000_0013;

endpackage

`default_nettype wire

// ==== rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

	// datapath and register index widths
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// byte address of the first fetch
	localparam word_t RESET_PC = 32'h0000_0000;

	// --------------------------------------------------------------------------
	// internal operation codes carried down the pipe
	// --------------------------------------------------------------------------
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE
	} mem_op_e;

endpackage

`default_nettype wire

// ==== rv_fetch.sv ====
`default_nettype none

module rv_fetch (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               stall_i,
	input  logic               redirect_i,
	input  rv_core_pkg::word_t redirect_pc_i,
	input  rv_core_pkg::word_t rom_data_i,
	output rv_core_pkg::word_t rom_addr_o,
	output rv_core_pkg::word_t id_pc_o,
	output rv_core_pkg::word_t id_inst_o,
	output logic               rom_ce_o
);

	// program counter and ROM enable
	rv_core_pkg::word_t pc_q;
	logic               ce_q;

	// --------------------------------------------------------------------------
	// PC
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ce_q <= 1'b0;
			pc_q <= rv_core_pkg::RESET_PC;
		end else begin
			// ROM comes on at the first edge after reset, still at RESET_PC
			ce_q <= 1'b1;
			// redirect wins, decode never raises it together with stall
			if (redirect_i) begin
				pc_q <= redirect_pc_i;
			end else if (ce_q && !stall_i) begin
				pc_q <= pc_q + 32'd4;
			end
		end
	end

	assign rom_addr_o = pc_q;
	assign rom_ce_o   = ce_q;

	// --------------------------------------------------------------------------
	// IF/ID
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			id_inst_o <= rv_isa_pkg::NOP_INST;
		end else if (redirect_i) begin
			// wrong path word behind a taken branch or jump
			id_inst_o <= rv_isa_pkg::NOP_INST;
		end else if (!stall_i) begin
			// nothing fetched yet while the ROM is off
			id_inst_o <= ce_q ? rom_data_i : rv_isa_pkg::NOP_INST;
		end
	end

	// pc of the word in IF/ID
	always_ff @(posedge clk) begin
		if (!stall_i) begin
			id_pc_o <= pc_q;
		end
	end

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
`default_nettype none

module rv_regfile (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  logic                   we_i,
	input  rv_core_pkg::reg_addr_t waddr_i,
	input  rv_core_pkg::reg_addr_t raddr1_i,
	input  rv_core_pkg::reg_addr_t raddr2_i,
	input  rv_core_pkg::word_t     wdata_i,
	output rv_core_pkg::word_t     rdata1_o,
	output rv_core_pkg::word_t     rdata2_o
);

	// x1 to x31, x0 has no storage
	rv_core_pkg::word_t regs_q [1:31];

	// one read port
	// x0 is zero, a write in the same cycle is seen at once
	function automatic rv_core_pkg::word_t read_port(input rv_core_pkg::reg_addr_t addr);
		rv_core_pkg::word_t data;
		if (addr == '0) begin
			data = '0;
		end else if (we_i && (waddr_i == addr)) begin
			data = wdata_i;
		end else begin
			data = regs_q[addr];
		end
		return data;
	endfunction

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs_q[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin
			regs_q[waddr_i] <= wdata_i;
		end
	end

	// two identical read ports
	always_comb begin
		rdata1_o = read_port(raddr1_i);
		rdata2_o = read_port(raddr2_i);
	end

endmodule

`default_nettype wire

// ==== rv_decode.sv ====
`default_nettype none

module rv_decode (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  rv_core_pkg::word_t     pc_i,
	input  rv_core_pkg::word_t     inst_i,
	input  rv_core_pkg::word_t     rdata1_i,
	input  rv_core_pkg::word_t     rdata2_i,
	input  rv_core_pkg::word_t     ex_result_i,
	input  rv_core_pkg::word_t     mem_wdata_i,
	input  logic                   mem_wreg_i,
	input  rv_core_pkg::reg_addr_t mem_wd_i,
	output rv_core_pkg::reg_addr_t raddr1_o,
	output rv_core_pkg::reg_addr_t raddr2_o,
	output logic                   stall_o,
	output logic                   redirect_o,
	output rv_core_pkg::word_t     redirect_pc_o,
	output rv_core_pkg::alu_op_e   ex_alu_op_o,
	output rv_core_pkg::word_t     ex_op1_o,
	output rv_core_pkg::word_t     ex_op2_o,
	output rv_core_pkg::word_t     ex_store_data_o,
	output rv_core_pkg::mem_op_e   ex_mem_op_o,
	output logic                   ex_wreg_o,
	output rv_core_pkg::reg_addr_t ex_wd_o
);

	// instruction fields
	rv_isa_pkg::opcode_e    opcode;
	logic [2:0]             funct3;
	rv_core_pkg::reg_addr_t rs1;
	rv_core_pkg::reg_addr_t rs2;
	rv_core_pkg::reg_addr_t rd;
	rv_core_pkg::word_t     imm_i;
	rv_core_pkg::word_t     imm_s;
	rv_core_pkg::word_t     imm_b;
	rv_core_pkg::word_t     imm_u;
	rv_core_pkg::word_t     imm_j;

	// forwarded sources
	rv_core_pkg::word_t     rs1_val;
	rv_core_pkg::word_t     rs2_val;

	// decoded controls headed for ID/EX
	rv_core_pkg::alu_op_e   alu_op_d;
	rv_core_pkg::mem_op_e   mem_op_d;
	rv_core_pkg::word_t     op1_d;
	rv_core_pkg::word_t     op2_d;
	rv_core_pkg::word_t     target_d;
	logic                   wreg_d;
	logic                   use_rs1;
	logic                   use_rs2;
	logic                   take;
	logic                   br_cond;

	assign opcode   = rv_isa_pkg::opcode_e'(inst_i[6:0]);
	assign funct3   = inst_i[14:12];
	assign rs1      = inst_i[19:15];
	assign rs2      = inst_i[24:20];
	assign rd       = inst_i[11:7];
	assign raddr1_o = rs1;
	assign raddr2_o = rs2;

	// sign extended immediates of each format
	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {inst_i[31:12], 12'b0};
	assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	// --------------------------------------------------------------------------
	// operand forwarding
	// --------------------------------------------------------------------------
	// youngest producer first, x0 never has a producer since wreg needs rd != 0
	function automatic rv_core_pkg::word_t fwd(input rv_core_pkg::reg_addr_t rs,
			input rv_core_pkg::word_t rf_val);
		rv_core_pkg::word_t val;
		if (ex_wreg_o && (ex_wd_o == rs)) begin
			val = ex_result_i;
		end else if (mem_wreg_i && (mem_wd_i == rs)) begin
			val = mem_wdata_i;
		end else begin
			val = rf_val;
		end
		return val;
	endfunction

	always_comb begin
		rs1_val = fwd(rs1, rdata1_i);
		rs2_val = fwd(rs2, rdata2_i);
	end

	// funct3 to ALU op, alt is inst bit 30
	function automatic rv_core_pkg::alu_op_e alu_sel(input logic [2:0] f3,
			input logic alt, input logic reg_op);
		rv_core_pkg::alu_op_e op;
		case (rv_isa_pkg::alu_funct3_e'(f3))
			rv_isa_pkg::F3_ADD_SUB: op = (reg_op && alt) ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
			rv_isa_pkg::F3_SLL:     op = rv_core_pkg::ALU_SLL;
			rv_isa_pkg::F3_SLT:     op = rv_core_pkg::ALU_SLT;
			rv_isa_pkg::F3_SLTU:    op = rv_core_pkg::ALU_SLTU;
			rv_isa_pkg::F3_XOR:     op = rv_core_pkg::ALU_XOR;
			rv_isa_pkg::F3_SR:      op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
			rv_isa_pkg::F3_OR:      op = rv_core_pkg::ALU_OR;
			default:                op = rv_core_pkg::ALU_AND;
		endcase
		return op;
	endfunction

	// branch condition on forwarded operands
	always_comb begin
		case (rv_isa_pkg::branch_funct3_e'(funct3))
			rv_isa_pkg::F3_BEQ:  br_cond = (rs1_val == rs2_val);
			rv_isa_pkg::F3_BNE:  br_cond = (rs1_val != rs2_val);
			rv_isa_pkg::F3_BLT:  br_cond = ($signed(rs1_val) < $signed(rs2_val));
			rv_isa_pkg::F3_BGE:  br_cond = ($signed(rs1_val) >= $signed(rs2_val));
			rv_isa_pkg::F3_BLTU: br_cond = (rs1_val < rs2_val);
			rv_isa_pkg::F3_BGEU: br_cond = (rs1_val >= rs2_val);
			default:             br_cond = 1'b0;
		endcase
	end

	// --------------------------------------------------------------------------
	// main decode
	// --------------------------------------------------------------------------
	always_comb begin
		alu_op_d = rv_core_pkg::ALU_ADD;
		mem_op_d = rv_core_pkg::MEM_NONE;
		op1_d    = rs1_val;
		op2_d    = imm_i;
		wreg_d   = 1'b0;
		use_rs1  = 1'b0;
		use_rs2  = 1'b0;
		take     = 1'b0;
		target_d = pc_i + imm_b;
		case (opcode)
			rv_isa_pkg::OPC_LUI: begin
				alu_op_d = rv_core_pkg::ALU_PASS_B;
				op2_d    = imm_u;
				wreg_d   = 1'b1;
			end
			rv_isa_pkg::OPC_AUIPC: begin
				op1_d  = pc_i;
				op2_d  = imm_u;
				wreg_d = 1'b1;
			end
			rv_isa_pkg::OPC_JAL: begin
				// link is pc plus four through the ALU
				op1_d    = pc_i;
				op2_d    = 32'd4;
				wreg_d   = 1'b1;
				take     = 1'b1;
				target_d = pc_i + imm_j;
			end
			rv_isa_pkg::OPC_JALR: begin
				op1_d       = pc_i;
				op2_d       = 32'd4;
				wreg_d      = 1'b1;
				use_rs1     = 1'b1;
				take        = 1'b1;
				target_d    = rs1_val + imm_i;
				target_d[0] = 1'b0;
			end
			rv_isa_pkg::OPC_BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				take    = br_cond;
			end
			rv_isa_pkg::OPC_LOAD: begin
				// word loads only, funct3 ignored
				mem_op_d = rv_core_pkg::MEM_LOAD;
				wreg_d   = 1'b1;
				use_rs1  = 1'b1;
			end
			rv_isa_pkg::OPC_STORE: begin
				mem_op_d = rv_core_pkg::MEM_STORE;
				op2_d    = imm_s;
				use_rs1  = 1'b1;
				use_rs2  = 1'b1;
			end
			rv_isa_pkg::OPC_OP_IMM: begin
				// shamt sits in the low bits of imm_i
				alu_op_d = alu_sel(funct3, inst_i[30], 1'b0);
				wreg_d   = 1'b1;
				use_rs1  = 1'b1;
			end
			rv_isa_pkg::OPC_OP: begin
				alu_op_d = alu_sel(funct3, inst_i[30], 1'b1);
				op2_d    = rs2_val;
				wreg_d   = 1'b1;
				use_rs1  = 1'b1;
				use_rs2  = 1'b1;
			end
			default: begin
				// unknown opcode runs as a no-op
				wreg_d = 1'b0;
			end
		endcase
		// rd of x0 never writes, keeps forwarding and stall simple
		wreg_d = wreg_d && (rd != '0);
	end

	// load in execute feeding this instruction
	assign stall_o = ex_wreg_o && (ex_mem_op_o == rv_core_pkg::MEM_LOAD) &&
		((use_rs1 && (ex_wd_o == rs1)) || (use_rs2 && (ex_wd_o == rs2)));

	// operands are stale while stalled so hold the redirect back
	assign redirect_o    = take && !stall_o;
	assign redirect_pc_o = target_d;

	// --------------------------------------------------------------------------
	// ID/EX
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_alu_op_o <= rv_core_pkg::ALU_ADD;
			ex_mem_op_o <= rv_core_pkg::MEM_NONE;
			ex_wreg_o   <= 1'b0;
		end else if (stall_o) begin
			// bubble
			ex_alu_op_o <= rv_core_pkg::ALU_ADD;
			ex_mem_op_o <= rv_core_pkg::MEM_NONE;
			ex_wreg_o   <= 1'b0;
		end else begin
			ex_alu_op_o <= alu_op_d;
			ex_mem_op_o <= mem_op_d;
			ex_wreg_o   <= wreg_d;
		end
	end

	// payload, meaningless under a bubble
	always_ff @(posedge clk) begin
		ex_op1_o        <= op1_d;
		ex_op2_o        <= op2_d;
		ex_store_data_o <= rs2_val;
		ex_wd_o         <= rd;
	end

endmodule

`default_nettype wire

// ==== rv_execute.sv ====
`default_nettype none

module rv_execute (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  rv_core_pkg::alu_op_e   alu_op_i,
	input  rv_core_pkg::word_t     op1_i,
	input  rv_core_pkg::word_t     op2_i,
	input  rv_core_pkg::word_t     store_data_i,
	input  rv_core_pkg::mem_op_e   mem_op_i,
	input  logic                   wreg_i,
	input  rv_core_pkg::reg_addr_t wd_i,
	output rv_core_pkg::word_t     result_o,
	output rv_core_pkg::word_t     mem_result_o,
	output rv_core_pkg::word_t     mem_store_data_o,
	output rv_core_pkg::mem_op_e   mem_op_o,
	output logic                   mem_wreg_o,
	output rv_core_pkg::reg_addr_t mem_wd_o
);

	rv_core_pkg::word_t alu_res;
	logic [4:0]         shamt;
	logic               lt_s;
	logic               lt_u;

	assign shamt = op2_i[4:0];
	assign lt_s  = ($signed(op1_i) < $signed(op2_i));
	assign lt_u  = (op1_i < op2_i);

	// --------------------------------------------------------------------------
	// ALU
	// --------------------------------------------------------------------------
	// loads and stores use ADD so the result is the RAM address
	always_comb begin
		case (alu_op_i)
			rv_core_pkg::ALU_ADD:    alu_res = op1_i + op2_i;
			rv_core_pkg::ALU_SUB:    alu_res = op1_i - op2_i;
			rv_core_pkg::ALU_SLL:    alu_res = op1_i << shamt;
			rv_core_pkg::ALU_SLT:    alu_res = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_s};
			rv_core_pkg::ALU_SLTU:   alu_res = {{(rv_core_pkg::XLEN-1){1'b0}}, lt_u};
			rv_core_pkg::ALU_XOR:    alu_res = op1_i ^ op2_i;
			rv_core_pkg::ALU_SRL:    alu_res = op1_i >> shamt;
			// sign bit fills from the left
			rv_core_pkg::ALU_SRA:    alu_res = $signed(op1_i) >>> shamt;
			rv_core_pkg::ALU_OR:     alu_res = op1_i | op2_i;
			rv_core_pkg::ALU_AND:    alu_res = op1_i & op2_i;
			rv_core_pkg::ALU_PASS_B: alu_res = op2_i;
			default:                 alu_res = '0;
		endcase
	end

	// back to decode for forwarding
	assign result_o = alu_res;

	// --------------------------------------------------------------------------
	// EX/MEM
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_op_o   <= rv_core_pkg::MEM_NONE;
			mem_wreg_o <= 1'b0;
		end else begin
			mem_op_o   <= mem_op_i;
			mem_wreg_o <= wreg_i;
		end
	end

	always_ff @(posedge clk) begin
		mem_result_o     <= alu_res;
		mem_store_data_o <= store_data_i;
		mem_wd_o         <= wd_i;
	end

endmodule

`default_nettype wire

// ==== rv_mem_stage.sv ====
`default_nettype none

module rv_mem_stage (
	input  logic                   clk,
	input  logic                   rst_n_i,
	input  rv_core_pkg::word_t     result_i,
	input  rv_core_pkg::word_t     store_data_i,
	input  rv_core_pkg::word_t     ram_data_i,
	input  rv_core_pkg::mem_op_e   mem_op_i,
	input  logic                   wreg_i,
	input  rv_core_pkg::reg_addr_t wd_i,
	output rv_core_pkg::word_t     ram_addr_o,
	output rv_core_pkg::word_t     ram_data_o,
	output rv_core_pkg::word_t     fwd_wdata_o,
	output rv_core_pkg::word_t     wb_wdata_o,
	output logic                   ram_we_o,
	output logic                   ram_ce_o,
	output logic                   fwd_wreg_o,
	output logic                   wb_we_o,
	output rv_core_pkg::reg_addr_t fwd_wd_o,
	output rv_core_pkg::reg_addr_t wb_waddr_o
);

	// result of this stage, RAM word for loads
	rv_core_pkg::word_t stage_data;

	// --------------------------------------------------------------------------
	// RAM port
	// --------------------------------------------------------------------------
	// EX/MEM resets to MEM_NONE so the RAM stays off in reset
	assign ram_ce_o   = (mem_op_i != rv_core_pkg::MEM_NONE);
	assign ram_we_o   = (mem_op_i == rv_core_pkg::MEM_STORE);
	assign ram_addr_o = result_i;
	assign ram_data_o = store_data_i;

	// read data is back in the same cycle
	assign stage_data = (mem_op_i == rv_core_pkg::MEM_LOAD) ? ram_data_i : result_i;

	// forward to decode
	assign fwd_wdata_o = stage_data;
	assign fwd_wreg_o  = wreg_i;
	assign fwd_wd_o    = wd_i;

	// --------------------------------------------------------------------------
	// MEM/WB
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_we_o <= 1'b0;
		end else begin
			wb_we_o <= wreg_i;
		end
	end

	always_ff @(posedge clk) begin
		wb_wdata_o <= stage_data;
		wb_waddr_o <= wd_i;
	end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`default_nettype none

module rv_core (
	input  logic               clk,
	input  logic               rst_n_i,
	input  rv_core_pkg::word_t rom_data_i,
	input  rv_core_pkg::word_t ram_data_i,
	output rv_core_pkg::word_t rom_addr_o,
	output rv_core_pkg::word_t ram_addr_o,
	output rv_core_pkg::word_t ram_data_o,
	output logic               rom_ce_o,
	output logic               ram_we_o,
	output logic               ram_ce_o
);

	// IF/ID and control back to fetch
	rv_core_pkg::word_t     id_pc;
	rv_core_pkg::word_t     id_inst;
	rv_core_pkg::word_t     redirect_pc;
	logic                   stall;
	logic                   redirect;

	// register file ports
	rv_core_pkg::reg_addr_t raddr1;
	rv_core_pkg::reg_addr_t raddr2;
	rv_core_pkg::word_t     rdata1;
	rv_core_pkg::word_t     rdata2;

	// ID/EX
	rv_core_pkg::alu_op_e   ex_alu_op;
	rv_core_pkg::word_t     ex_op1;
	rv_core_pkg::word_t     ex_op2;
	rv_core_pkg::word_t     ex_store_data;
	rv_core_pkg::mem_op_e   ex_mem_op;
	logic                   ex_wreg;
	rv_core_pkg::reg_addr_t ex_wd;
	rv_core_pkg::word_t     ex_result;

	// EX/MEM and memory stage forwarding
	rv_core_pkg::word_t     mem_result;
	rv_core_pkg::word_t     mem_store_data;
	rv_core_pkg::mem_op_e   mem_op;
	logic                   mem_wreg;
	rv_core_pkg::reg_addr_t mem_wd;
	rv_core_pkg::word_t     fwd_wdata;
	logic                   fwd_wreg;
	rv_core_pkg::reg_addr_t fwd_wd;

	// MEM/WB
	rv_core_pkg::word_t     wb_wdata;
	logic                   wb_we;
	rv_core_pkg::reg_addr_t wb_waddr;

	// --------------------------------------------------------------------------
	// fetch
	// --------------------------------------------------------------------------
	rv_fetch u_fetch (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.stall_i       (stall),
		.redirect_i    (redirect),
		.redirect_pc_i (redirect_pc),
		.rom_data_i    (rom_data_i),
		.rom_addr_o    (rom_addr_o),
		.id_pc_o       (id_pc),
		.id_inst_o     (id_inst),
		.rom_ce_o      (rom_ce_o)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.we_i     (wb_we),
		.waddr_i  (wb_waddr),
		.raddr1_i (raddr1),
		.raddr2_i (raddr2),
		.wdata_i  (wb_wdata),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	// --------------------------------------------------------------------------
	// decode, stall and redirect source
	// --------------------------------------------------------------------------
	rv_decode u_decode (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.pc_i            (id_pc),
		.inst_i          (id_inst),
		.rdata1_i        (rdata1),
		.rdata2_i        (rdata2),
		.ex_result_i     (ex_result),
		.mem_wdata_i     (fwd_wdata),
		.mem_wreg_i      (fwd_wreg),
		.mem_wd_i        (fwd_wd),
		.raddr1_o        (raddr1),
		.raddr2_o        (raddr2),
		.stall_o         (stall),
		.redirect_o      (redirect),
		.redirect_pc_o   (redirect_pc),
		.ex_alu_op_o     (ex_alu_op),
		.ex_op1_o        (ex_op1),
		.ex_op2_o        (ex_op2),
		.ex_store_data_o (ex_store_data),
		.ex_mem_op_o     (ex_mem_op),
		.ex_wreg_o       (ex_wreg),
		.ex_wd_o         (ex_wd)
	);

	rv_execute u_execute (
		.clk              (clk),
		.rst_n_i          (rst_n_i),
		.alu_op_i         (ex_alu_op),
		.op1_i            (ex_op1),
		.op2_i            (ex_op2),
		.store_data_i     (ex_store_data),
		.mem_op_i         (ex_mem_op),
		.wreg_i           (ex_wreg),
		.wd_i             (ex_wd),
		.result_o         (ex_result),
		.mem_result_o     (mem_result),
		.mem_store_data_o (mem_store_data),
		.mem_op_o         (mem_op),
		.mem_wreg_o       (mem_wreg),
		.mem_wd_o         (mem_wd)
	);

	// --------------------------------------------------------------------------
	// memory stage and data RAM port
	// --------------------------------------------------------------------------
	rv_mem_stage u_mem_stage (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.result_i     (mem_result),
		.store_data_i (mem_store_data),
		.ram_data_i   (ram_data_i),
		.mem_op_i     (mem_op),
		.wreg_i       (mem_wreg),
		.wd_i         (mem_wd),
		.ram_addr_o   (ram_addr_o),
		.ram_data_o   (ram_data_o),
		.fwd_wdata_o  (fwd_wdata),
		.wb_wdata_o   (wb_wdata),
		.ram_we_o     (ram_we_o),
		.ram_ce_o     (ram_ce_o),
		.fwd_wreg_o   (fwd_wreg),
		.wb_we_o      (wb_we),
		.fwd_wd_o     (fwd_wd),
		.wb_waddr_o   (wb_waddr)
	);

endmodule

`default_nettype wire

// ==== rv_core_chk.sv ====
`default_nettype none

module rv_core_chk (
	input logic               clk,
	input logic               rst_n_i,
	input rv_core_pkg::word_t rom_addr_i,
	input rv_core_pkg::word_t ram_addr_i,
	input logic               ram_ce_i,
	input logic               ram_we_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// failed assertions so far
	int fail_count = 0;

	// a write always comes with the enable
	we_has_ce: assert property (@(posedge clk) disable iff (!rst_n_i)
		ram_we_i |-> ram_ce_i)
		else begin
			$error("ram_we_o high without ram_ce_o");
			fail_count++;
		end

	// word accesses only
	ram_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
		ram_ce_i |-> (ram_addr_i[1:0] == 2'b00))
		else begin
			$error("ram_addr_o not word aligned");
			fail_count++;
		end

	rom_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
		rom_addr_i[1:0] == 2'b00)
		else begin
			$error("rom_addr_o not word aligned");
			fail_count++;
		end

endmodule

`default_nettype wire

// ==== rv_store_scoreboard.sv ====
`default_nettype none

module rv_store_scoreboard (
	input  logic               clk,
	input  logic               rst_n_i,
	input  logic               rom_ce_i,
	input  rv_core_pkg::word_t rom_addr_i,
	input  logic               ram_ce_i,
	input  logic               ram_we_i,
	input  rv_core_pkg::word_t ram_addr_i,
	input  rv_core_pkg::word_t ram_data_i,
	output int                 errors_o,
	output int                 seen_o,
	output int                 expected_o,
	output logic               done_o
);
	timeunit 1ns;
	timeprecision 1ps;

	// expected stores in file order
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	int          errors;
	int          seen;
	logic        first_fetch_pending;

	initial begin
		int          fd;
		int          n;
		string       line;
		logic [31:0] a;
		logic [31:0] d;
		errors              = 0;
		seen                = 0;
		first_fetch_pending = 1'b1;
		fd = $fopen("rv_tests.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && line.len() > 0 && line[0] == "s") begin
					if ($sscanf(line, "s %h %h", a, d) == 2) begin
						exp_addr.push_back(a);
						exp_data.push_back(d);
					end
				end
			end
			$fclose(fd);
		end
	end

	assign errors_o   = errors;
	assign seen_o     = seen;
	assign expected_o = exp_addr.size();
	assign done_o     = (exp_addr.size() > 0) && (seen == exp_addr.size());

	// sampled at the rising edge, before the DUT registers move
	always @(posedge clk) begin
		if (!rst_n_i) begin
			// no memory enable while reset is held
			if (rom_ce_i || ram_ce_i || ram_we_i) begin
				$display("a memory enable is high while reset is held");
				errors++;
			end
			first_fetch_pending = 1'b1;
		end else begin
			// first fetch after release
			if (first_fetch_pending && rom_ce_i) begin
				first_fetch_pending = 1'b0;
				if (rom_addr_i !== rv_core_pkg::RESET_PC) begin
					$display("FAILED rom_addr_o: got %h expected %h",
						rom_addr_i, rv_core_pkg::RESET_PC);
					errors++;
				end
			end
			if (ram_ce_i && ram_we_i) begin
				if (seen >= exp_addr.size()) begin
					$display("unexpected store to address %h after all expected stores",
						ram_addr_i);
					errors++;
				end else begin
					if (ram_addr_i !== exp_addr[seen]) begin
						$display("FAILED ram_addr_o: got %h expected %h",
							ram_addr_i, exp_addr[seen]);
						errors++;
					end
					if (ram_data_i !== exp_data[seen]) begin
						$display("FAILED ram_data_o: got %h expected %h",
							ram_data_i, exp_data[seen]);
						errors++;
					end
				end
				seen++;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
`default_nettype none

module tb_rv_core;
	timeunit 1ns;
	timeprecision 1ps;

	// DUT ports
	logic               clk;
	logic               rst_n_i;
	rv_core_pkg::word_t rom_data;
	rv_core_pkg::word_t ram_rdata;
	rv_core_pkg::word_t rom_addr;
	rv_core_pkg::word_t ram_addr;
	rv_core_pkg::word_t ram_wdata;
	logic               rom_ce;
	logic               ram_we;
	logic               ram_ce;

	// scoreboard status
	int                 sb_errors;
	int                 sb_seen;
	int                 sb_expected;
	logic               sb_done;

	// program image and data RAM model
	rv_core_pkg::word_t prog_mem [0:255];
	rv_core_pkg::word_t ram_mem  [0:63];
	int                 prog_len;
	int                 load_errors;
	int                 assert_errors;
	int                 cycles;
	int                 limit;
	int                 total_errors;
	logic               timed_out;

	rv_core u_rv_core (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rom_data_i (rom_data),
		.ram_data_i (ram_rdata),
		.rom_addr_o (rom_addr),
		.ram_addr_o (ram_addr),
		.ram_data_o (ram_wdata),
		.rom_ce_o   (rom_ce),
		.ram_we_o   (ram_we),
		.ram_ce_o   (ram_ce)
	);

	rv_store_scoreboard u_scoreboard (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rom_ce_i   (rom_ce),
		.rom_addr_i (rom_addr),
		.ram_ce_i   (ram_ce),
		.ram_we_i   (ram_we),
		.ram_addr_i (ram_addr),
		.ram_data_i (ram_wdata),
		.errors_o   (sb_errors),
		.seen_o     (sb_seen),
		.expected_o (sb_expected),
		.done_o     (sb_done)
	);

	// memory port assertions live inside the core
	bind rv_core rv_core_chk u_core_chk (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.rom_addr_i (rom_addr_o),
		.ram_addr_i (ram_addr_o),
		.ram_ce_i   (ram_ce_o),
		.ram_we_i   (ram_we_o)
	);

	// ------------------------------------------------------------------------
	// clock and memory models
	// ------------------------------------------------------------------------
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ROM answers in the same cycle, NOP past the program
	always_comb begin
		if (rom_addr[31:2] < prog_len) begin
			rom_data = prog_mem[rom_addr[9:2]];
		end else begin
			rom_data = rv_isa_pkg::NOP_INST;
		end
	end

	assign ram_rdata = ram_mem[ram_addr[7:2]];

	always @(posedge clk) begin
		if (ram_ce && ram_we) begin
			ram_mem[ram_addr[7:2]] <= ram_wdata;
		end
	end

	// program words from the data file, store lines are for the scoreboard
	task automatic load_program();
		int          fd;
		int          n;
		string       line;
		logic [31:0] word;
		fd = $fopen("rv_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open rv_tests.txt");
			load_errors++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 0 && line[0] == "p") begin
				if ($sscanf(line, "p %h", word) == 1 && prog_len < 256) begin
					prog_mem[prog_len] = word;
					prog_len++;
				end
			end
		end
		$fclose(fd);
	endtask

	// ------------------------------------------------------------------------
	// run
	// ------------------------------------------------------------------------
	initial begin
		rst_n_i       = 1'b0;
		prog_len      = 0;
		load_errors   = 0;
		assert_errors = 0;
		timed_out     = 1'b0;
		cycles        = 0;
		for (int i = 0; i < 64; i++) begin
			ram_mem[i] = '0;
		end
		load_program();
		if (prog_len == 0) begin
			$display("no program words found in rv_tests.txt");
			load_errors++;
		end
		// 16 cycles of reset, released on a falling edge
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n_i = 1'b1;
		limit = 4 * prog_len + 64;
		// status settles between rising edges
		while (!sb_done && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!sb_done) begin
			timed_out = 1'b1;
			$display("timeout after %0d cycles, only %0d of %0d expected stores seen",
				cycles, sb_seen, sb_expected);
		end
		// a few more cycles to catch stray stores
		repeat (8) @(negedge clk);
		assert_errors = u_rv_core.u_core_chk.fail_count;
		total_errors  = sb_errors + load_errors + assert_errors + (timed_out ? 1 : 0);
		$display("errors: %0d, assertion failures: %0d, stores seen: %0d of %0d, cycles: %0d",
			total_errors, assert_errors, sb_seen, sb_expected, cycles);
		if (total_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== rv_tests.txt ====
# p <instruction word hex>, one per program word from address 0
# s <store address hex> <store data hex>, expected stores in order
p ff800093
p 4010d113
p 123451b7
p 00218233
p 00402023
p 00002283
p 40128333
p 00602223
p 0030a3b3
p 0000c463
p 00102423
p 0080046f
p 00002623
p 007404b3
p 00902423
p 00000517
p 00050463
p 00a02623
p 0000006f
s 00000000 12344ffc
s 00000004 12345004
s 00000008 00000031
s 0000000c 0000003c

// ==== all.f ====
rv_isa_pkg.sv
rv_core_pkg.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_mem_stage.sv
rv_core.sv
rv_core_chk.sv
rv_store_scoreboard.sv
tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the RV32I pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_rv_core -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^>>> PASS$" sim.log; then
	exit 0
fi
exit 1
